//--- Makefile
TOP = tb_fix_parser
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- fix_byte_tokenizer.sv
`timescale 1ns/1ps

module fix_byte_tokenizer (
	input  logic                     clk,
	input  logic                     rst,
	input  fix_types_pkg::fix_byte_t byte_i,
	input  logic                     byte_valid_i,
	output fix_types_pkg::fix_byte_t data_o,
	output logic                     tag_byte_o,
	output logic                     value_byte_o,
	output logic                     tag_done_o,
	output logic                     value_done_o,
	output logic                     end_detected_o
);

	fix_types_pkg::tok_state_e tok_state;
	fix_types_pkg::end_state_e end_state;
	fix_types_pkg::end_state_e end_next;

	logic is_soh;
	logic is_eq;
	logic end_hit;

	assign is_soh = (byte_i == fix_proto_pkg::soh_char);
	assign is_eq  = (byte_i == fix_proto_pkg::eq_char);

	// ======================================================================
	// tag / value classification
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			tok_state    <= fix_types_pkg::tok_tag;
			tag_byte_o   <= 1'b0;
			value_byte_o <= 1'b0;
			tag_done_o   <= 1'b0;
			value_done_o <= 1'b0;
		end else begin
			tag_byte_o   <= 1'b0; // strobes last one cycle.
			value_byte_o <= 1'b0;
			tag_done_o   <= 1'b0;
			value_done_o <= 1'b0;
			if (byte_valid_i) begin
				case (tok_state)
					fix_types_pkg::tok_tag: begin
						if (is_eq) begin
							tag_done_o <= 1'b1;
							tok_state  <= fix_types_pkg::tok_value;
						end else if (!is_soh) begin
							tag_byte_o <= 1'b1; // a stray SOH in a tag is dropped.
						end
					end
					default: begin
						if (is_soh) begin
							value_done_o <= 1'b1;
							tok_state    <= fix_types_pkg::tok_tag;
						end else begin
							value_byte_o <= 1'b1; // "=" inside a value is plain data.
						end
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (byte_valid_i)
			data_o <= byte_i; // lines up with the strobes.
	end

	// ======================================================================
	// end pattern SOH "10="
	// ======================================================================

	always_comb begin
		end_next = end_state;
		end_hit  = 1'b0;
		if (byte_valid_i) begin
			end_next = fix_types_pkg::end_idle;
			if (is_soh) begin
				end_next = fix_types_pkg::end_soh; // any SOH restarts the match.
			end else begin
				case (end_state)
					fix_types_pkg::end_soh:
						if (byte_i == fix_proto_pkg::tag_checksum[15:8])
							end_next = fix_types_pkg::end_one;
					fix_types_pkg::end_one:
						if (byte_i == fix_proto_pkg::tag_checksum[7:0])
							end_next = fix_types_pkg::end_zero;
					fix_types_pkg::end_zero:
						end_hit = is_eq;
					default:
						end_hit = 1'b0;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			end_state      <= fix_types_pkg::end_idle;
			end_detected_o <= 1'b0;
		end else begin
			end_state      <= end_next;
			end_detected_o <= end_hit;
		end
	end

	// the "=" of SOH "10=" always closes a tag.
	assert property (@(posedge clk) disable iff (rst) end_detected_o |-> tag_done_o)
		else $error("end pattern outside a tag");

endmodule

//--- fix_field_assembler.sv
`timescale 1ns/1ps

module fix_field_assembler (
	input  logic                     clk,
	input  logic                     rst,
	input  fix_types_pkg::fix_byte_t data_i,
	input  logic                     tag_byte_i,
	input  logic                     value_byte_i,
	input  logic                     tag_done_i,
	input  logic                     value_done_i,
	input  logic                     end_detected_i,
	output logic                     tag_wr_o,
	output logic [33:0]              tag_wdata_o,
	output logic                     value_wr_o,
	output logic [261:0]             value_wdata_o,
	input  logic                     tag_full_i,
	input  logic                     value_full_i,
	output logic                     overflow_o
);

	localparam fix_types_pkg::fix_len_t LEN_MAX = 6'd32;

	fix_types_pkg::fix_tag_t   tag_q;
	fix_types_pkg::fix_value_t value_q;
	fix_types_pkg::fix_len_t   len_q;

	logic tag_open_q; // a tag byte has arrived since the last write.
	logic tag_is_begin;
	logic tag_is_end;

	assign tag_is_begin = (tag_q == fix_proto_pkg::tag_begin_string);

	// the "=" of SOH "10=" comes with the tag done strobe.
	assign tag_is_end = (tag_q == fix_proto_pkg::tag_checksum) || end_detected_i;

	// ======================================================================
	// tag and value shift registers
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			tag_q      <= '0;
			tag_open_q <= 1'b0;
		end else if (tag_done_i) begin
			tag_q      <= '0;
			tag_open_q <= 1'b0;
		end else if (tag_byte_i) begin
			tag_open_q <= 1'b1;
			if (tag_open_q)
				tag_q <= {tag_q[23:0], data_i}; // oldest byte falls off the top.
			else
				tag_q <= {24'h000000, data_i};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			value_q <= '0;
			len_q   <= '0;
		end else if (value_done_i) begin
			value_q <= '0;
			len_q   <= '0;
		end else if (value_byte_i) begin
			if (len_q == '0)
				value_q <= {248'h0, data_i};
			else
				value_q <= {value_q[247:0], data_i}; // keeps the last 32 bytes.
			if (len_q != LEN_MAX)
				len_q <= len_q + 6'd1;
		end
	end

	// ======================================================================
	// FIFO writes
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			tag_wr_o   <= 1'b0;
			value_wr_o <= 1'b0;
			overflow_o <= 1'b0;
		end else begin
			tag_wr_o   <= tag_done_i;
			value_wr_o <= value_done_i;
			// a write into a full FIFO is lost, so flag it until reset.
			if ((tag_wr_o && tag_full_i) || (value_wr_o && value_full_i))
				overflow_o <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (tag_done_i)
			tag_wdata_o <= {tag_is_begin, tag_is_end, tag_q};
		if (value_done_i)
			value_wdata_o <= {len_q, value_q};
	end

	// tags and values alternate in the stream.
	assert property (@(posedge clk) disable iff (rst) !(tag_wr_o && value_wr_o))
		else $error("tag and value written in one cycle");

endmodule

//--- fix_field_fifo.sv
`timescale 1ns/1ps

module fix_field_fifo #(
	parameter int WIDTH = 34,
	parameter int DEPTH = 8
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             wr_i,
	input  logic [WIDTH-1:0] wr_data_i,
	input  logic             rd_i,
	output logic [WIDTH-1:0] rd_data_o,
	output logic             full_o,
	output logic             empty_o
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [CW-1:0]    count;
	logic [CW-1:0]    count_next;
	logic             wr_ok;
	logic             rd_ok;

	// pointers wrap at DEPTH, which need not be a power of two.
	function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
		if (ptr == AW'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign wr_ok      = wr_i && !full_o;
	assign rd_ok      = rd_i && !empty_o;
	assign count_next = count + CW'(wr_ok) - CW'(rd_ok);
	assign rd_data_o  = mem[rd_ptr]; // head word, valid while not empty.

	always_ff @(posedge clk) begin
		if (wr_ok)
			mem[wr_ptr] <= wr_data_i;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			full_o  <= 1'b0;
			empty_o <= 1'b1;
		end else begin
			if (wr_ok)
				wr_ptr <= ptr_inc(wr_ptr);
			if (rd_ok)
				rd_ptr <= ptr_inc(rd_ptr);
			count   <= count_next;
			full_o  <= (count_next == CW'(DEPTH)); // status from the next count.
			empty_o <= (count_next == '0);
		end
	end

	// the reader must wait for data.
	assert property (@(posedge clk) disable iff (rst) rd_i |-> !empty_o)
		else $error("read while empty");

endmodule

//--- fix_field_reader.sv
`timescale 1ns/1ps

module fix_field_reader (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       tag_empty_i,
	input  logic                       value_empty_i,
	input  logic [33:0]                tag_rdata_i,
	input  logic [261:0]               value_rdata_i,
	output logic                       tag_rd_o,
	output logic                       value_rd_o,
	output logic                       field_valid_o,
	output fix_types_pkg::fix_tag_t    field_tag_o,
	output fix_types_pkg::fix_value_t  field_value_o,
	output fix_types_pkg::fix_len_t    field_len_o,
	output fix_types_pkg::fix_index_t  field_index_o,
	output logic                       msg_start_o,
	output logic                       msg_end_o,
	input  logic                       field_ready_i
);

	fix_types_pkg::rd_state_e  rd_state;
	fix_types_pkg::fix_index_t idx_q; // index of the next field.

	logic pop_q;
	logic rec_begin;

	assign rec_begin  = tag_rdata_i[33];
	assign tag_rd_o   = pop_q; // both FIFOs pop together.
	assign value_rd_o = pop_q;

	// ======================================================================
	// pop control
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_state      <= fix_types_pkg::rd_idle;
			pop_q         <= 1'b0;
			field_valid_o <= 1'b0;
			idx_q         <= '0;
		end else begin
			pop_q         <= 1'b0;
			field_valid_o <= 1'b0;
			case (rd_state)
				fix_types_pkg::rd_idle: begin
					if (!tag_empty_i && !value_empty_i && field_ready_i) begin
						pop_q    <= 1'b1;
						rd_state <= fix_types_pkg::rd_hold;
					end
				end
				default: begin
					// pop takes effect on this edge, the record goes out.
					field_valid_o <= 1'b1;
					rd_state      <= fix_types_pkg::rd_idle;
					idx_q         <= rec_begin ? 8'd1 : idx_q + 8'd1;
				end
			endcase
		end
	end

	// record registers hold until the next field.
	always_ff @(posedge clk) begin
		if (rd_state == fix_types_pkg::rd_hold) begin
			field_tag_o   <= tag_rdata_i[31:0];
			msg_start_o   <= rec_begin;
			msg_end_o     <= tag_rdata_i[32];
			field_value_o <= value_rdata_i[255:0];
			field_len_o   <= value_rdata_i[261:256];
			field_index_o <= rec_begin ? 8'd0 : idx_q; // tag 8 restarts the count.
		end
	end

endmodule

//--- fix_parser_top.sv
`timescale 1ns/1ps

module fix_parser_top #(
	parameter int TAG_DEPTH   = 8,
	parameter int VALUE_DEPTH = 8
) (
	input  logic                      clk,
	input  logic                      rst,
	input  fix_types_pkg::fix_byte_t  byte_i,
	input  logic                      byte_valid_i,
	input  logic                      field_ready_i,
	output logic                      field_valid_o,
	output fix_types_pkg::fix_tag_t   field_tag_o,
	output fix_types_pkg::fix_value_t field_value_o,
	output fix_types_pkg::fix_len_t   field_len_o,
	output fix_types_pkg::fix_index_t field_index_o,
	output logic                      msg_start_o,
	output logic                      msg_end_o,
	output logic                      overflow_o
);

	// FIFO words are {begin, end, tag} and {len, value}.
	localparam int TAG_W   = 34;
	localparam int VALUE_W = 262;

	fix_types_pkg::fix_byte_t tok_data;
	logic                     tok_tag_byte;
	logic                     tok_value_byte;
	logic                     tok_tag_done;
	logic                     tok_value_done;
	logic                     tok_end;

	logic               tag_wr;
	logic [TAG_W-1:0]   tag_wdata;
	logic               tag_rd;
	logic [TAG_W-1:0]   tag_rdata;
	logic               tag_full;
	logic               tag_empty;
	logic               value_wr;
	logic [VALUE_W-1:0] value_wdata;
	logic               value_rd;
	logic [VALUE_W-1:0] value_rdata;
	logic               value_full;
	logic               value_empty;

	// ======================================================================
	// byte stream to FIFOs
	// ======================================================================

	fix_byte_tokenizer tokenizer_inst (
		.clk            (clk),
		.rst            (rst),
		.byte_i         (byte_i),
		.byte_valid_i   (byte_valid_i),
		.data_o         (tok_data),
		.tag_byte_o     (tok_tag_byte),
		.value_byte_o   (tok_value_byte),
		.tag_done_o     (tok_tag_done),
		.value_done_o   (tok_value_done),
		.end_detected_o (tok_end)
	);

	fix_field_assembler assembler_inst (
		.clk            (clk),
		.rst            (rst),
		.data_i         (tok_data),
		.tag_byte_i     (tok_tag_byte),
		.value_byte_i   (tok_value_byte),
		.tag_done_i     (tok_tag_done),
		.value_done_i   (tok_value_done),
		.end_detected_i (tok_end),
		.tag_wr_o       (tag_wr),
		.tag_wdata_o    (tag_wdata),
		.value_wr_o     (value_wr),
		.value_wdata_o  (value_wdata),
		.tag_full_i     (tag_full),
		.value_full_i   (value_full),
		.overflow_o     (overflow_o)
	);

	fix_field_fifo #(.WIDTH(TAG_W), .DEPTH(TAG_DEPTH)) tag_fifo_inst (
		.clk       (clk),
		.rst       (rst),
		.wr_i      (tag_wr),
		.wr_data_i (tag_wdata),
		.rd_i      (tag_rd),
		.rd_data_o (tag_rdata),
		.full_o    (tag_full),
		.empty_o   (tag_empty)
	);

	fix_field_fifo #(.WIDTH(VALUE_W), .DEPTH(VALUE_DEPTH)) value_fifo_inst (
		.clk       (clk),
		.rst       (rst),
		.wr_i      (value_wr),
		.wr_data_i (value_wdata),
		.rd_i      (value_rd),
		.rd_data_o (value_rdata),
		.full_o    (value_full),
		.empty_o   (value_empty)
	);

	// ======================================================================
	// FIFOs to field records
	// ======================================================================

	fix_field_reader reader_inst (
		.clk           (clk),
		.rst           (rst),
		.tag_empty_i   (tag_empty),
		.value_empty_i (value_empty),
		.tag_rdata_i   (tag_rdata),
		.value_rdata_i (value_rdata),
		.tag_rd_o      (tag_rd),
		.value_rd_o    (value_rd),
		.field_valid_o (field_valid_o),
		.field_tag_o   (field_tag_o),
		.field_value_o (field_value_o),
		.field_len_o   (field_len_o),
		.field_index_o (field_index_o),
		.msg_start_o   (msg_start_o),
		.msg_end_o     (msg_end_o),
		.field_ready_i (field_ready_i)
	);

endmodule

//--- fix_proto_pkg.sv
package fix_proto_pkg;

	// ======================================================================
	// delimiters
	// ======================================================================

	// every field ends with SOH.
	localparam logic [7:0] soh_char = 8'h01;

	localparam logic [7:0] eq_char = 8'h3d; // "=" splits tag from value.

	// ======================================================================
	// special tags
	// ======================================================================

	// tags are kept as right-aligned ASCII, so "10" is 8'h31 then 8'h30.
	localparam logic [31:0] tag_begin_string = 32'h00000038; // "8", opens a message.

	// "10" is the checksum field, always the last one of a message.
	// its low two bytes also give the "1" and "0" of the end pattern.
	localparam logic [31:0] tag_checksum = 32'h00003130;

endpackage

//--- fix_types_pkg.sv
package fix_types_pkg;

	// ======================================================================
	// data widths
	// ======================================================================

	typedef logic [7:0] fix_byte_t; // one ASCII character.

	// up to four tag characters, last one in the low byte.
	typedef logic [31:0] fix_tag_t;

	// up to 32 value characters, last one in the low byte.
	typedef logic [255:0] fix_value_t;

	typedef logic [5:0] fix_len_t; // value length, 0 to 32.
	typedef logic [7:0] fix_index_t; // field number within a message.

	// ======================================================================
	// state machines
	// ======================================================================

	// tokenizer, inside a tag or inside a value.
	typedef enum logic {tok_tag, tok_value} tok_state_e;

	// matcher for SOH "1" "0" "=".
	typedef enum logic [1:0] {end_idle, end_soh, end_one, end_zero} end_state_e;

	typedef enum logic {rd_idle, rd_hold} rd_state_e; // reader.

endpackage

//--- tb_fix_parser.sv
`timescale 1ns/1ps

module tb_fix_parser;

	localparam int MODE_RANDOM = 0; // idle gaps and random ready drops.
	localparam int MODE_TIMED  = 1; // back-to-back bytes, latency is checked.
	localparam int MODE_STALL  = 2; // reader held off until the FIFOs overflow.

	logic                      clk;
	logic                      rst;
	fix_types_pkg::fix_byte_t  byte_i;
	logic                      byte_valid_i;
	logic                      field_ready_i;
	logic                      field_valid_o;
	fix_types_pkg::fix_tag_t   field_tag_o;
	fix_types_pkg::fix_value_t field_value_o;
	fix_types_pkg::fix_len_t   field_len_o;
	fix_types_pkg::fix_index_t field_index_o;
	logic                      msg_start_o;
	logic                      msg_end_o;
	logic                      overflow_o;

	// one message string per row, "|" stands for SOH.
	string msg_q[$];
	int    mode_q[$];
	int    row_nexp_q[$];
	// expected records of all rows in arrival order.
	string exp_tag_q[$];
	string exp_val_q[$];
	int    exp_len_q[$];
	int    exp_start_q[$];
	int    exp_end_q[$];
	int    exp_idx_q[$];

	int   table_bytes  = 0;
	logic table_loaded = 1'b0;
	int   rec_count    = 0;
	int   checks       = 0;
	int   errors       = 0;
	int   cycle_cnt    = 0; // rising edges seen so far.
	logic timing_on    = 1'b0;
	int   soh_cycle_q[$];

	fix_parser_top #(.TAG_DEPTH(8), .VALUE_DEPTH(8)) fix_parser_top_inst (
		.clk           (clk),
		.rst           (rst),
		.byte_i        (byte_i),
		.byte_valid_i  (byte_valid_i),
		.field_ready_i (field_ready_i),
		.field_valid_o (field_valid_o),
		.field_tag_o   (field_tag_o),
		.field_value_o (field_value_o),
		.field_len_o   (field_len_o),
		.field_index_o (field_index_o),
		.msg_start_o   (msg_start_o),
		.msg_end_o     (msg_end_o),
		.overflow_o    (overflow_o)
	);

	// ======================================================================
	// stimulus table
	// ======================================================================

	task automatic add_row(input string msg, input int mode);
		msg_q.push_back(msg);
		mode_q.push_back(mode);
		row_nexp_q.push_back(0);
		table_bytes += msg.len();
	endtask

	task automatic add_field(input string tag, input string val, input int len,
			input int start, input int is_end, input int idx);
		exp_tag_q.push_back(tag);
		exp_val_q.push_back(val);
		exp_len_q.push_back(len);
		exp_start_q.push_back(start);
		exp_end_q.push_back(is_end);
		exp_idx_q.push_back(idx);
		row_nexp_q[row_nexp_q.size() - 1] = row_nexp_q[row_nexp_q.size() - 1] + 1;
	endtask

	task automatic load_table();
		add_row("8=FIX.4.2|35=D|10=123|", MODE_RANDOM);
		add_field("8", "FIX.4.2", 7, 1, 0, 0);
		add_field("35", "D", 1, 0, 0, 1);
		add_field("10", "123", 3, 0, 1, 2);
		add_row("8=FIX.4.4|35=0|10=001|8=FIX.4.4|35=1|10=002|", MODE_RANDOM);
		add_field("8", "FIX.4.4", 7, 1, 0, 0);
		add_field("35", "0", 1, 0, 0, 1);
		add_field("10", "001", 3, 0, 1, 2);
		add_field("8", "FIX.4.4", 7, 1, 0, 0); // index restarts on tag 8.
		add_field("35", "1", 1, 0, 0, 1);
		add_field("10", "002", 3, 0, 1, 2);
		// 40 value bytes and a 5 character tag, only the tails are kept.
		add_row("8=FIX.4.2|58=ABCDEFGHIJKLMNOPQRSTUVWXYZ0123456789abcd|12345=X|10=200|",
			MODE_RANDOM);
		add_field("8", "FIX.4.2", 7, 1, 0, 0);
		add_field("58", "IJKLMNOPQRSTUVWXYZ0123456789abcd", 32, 0, 0, 1);
		add_field("2345", "X", 1, 0, 0, 2);
		add_field("10", "200", 3, 0, 1, 3);
		add_row("8=FIX.4.2|35=A|10=000|", MODE_TIMED);
		add_field("8", "FIX.4.2", 7, 1, 0, 0);
		add_field("35", "A", 1, 0, 0, 1);
		add_field("10", "000", 3, 0, 1, 2);
		// eleven fields into depth 8, the last three are dropped.
		add_row("8=FIX.4.2|35=8|11=A1|17=E2|37=O3|38=100|39=2|44=5|54=1|55=IBM|10=099|",
			MODE_STALL);
		add_field("8", "FIX.4.2", 7, 1, 0, 0);
		add_field("35", "8", 1, 0, 0, 1);
		add_field("11", "A1", 2, 0, 0, 2);
		add_field("17", "E2", 2, 0, 0, 3);
		add_field("37", "O3", 2, 0, 0, 4);
		add_field("38", "100", 3, 0, 0, 5);
		add_field("39", "2", 1, 0, 0, 6);
		add_field("44", "5", 1, 0, 0, 7);
		table_loaded = 1'b1;
	endtask

	// ASCII text right-aligned, the last character in the low byte.
	function automatic logic [255:0] pack_ascii(input string s);
		logic [255:0] v;
		int i;
		v = '0;
		for (i = 0; i < s.len(); i++)
			v = {v[247:0], s[i]};
		return v;
	endfunction

	// ready drops on about one cycle in four.
	function automatic logic draw_ready();
		return ($urandom % 4) != 0;
	endfunction

	// ======================================================================
	// driver and checks
	// ======================================================================

	task automatic send_row(input int r);
		string s;
		int i;
		int gap;
		fix_types_pkg::fix_byte_t c;
		s = msg_q[r];
		for (i = 0; i < s.len(); i++) begin
			c = s[i];
			if (c == "|")
				c = fix_proto_pkg::soh_char;
			if (mode_q[r] == MODE_RANDOM) begin
				gap = $urandom % 4;
				repeat (gap) begin
					@(posedge clk);
					byte_valid_i  <= 1'b0;
					field_ready_i <= draw_ready();
				end
			end
			@(posedge clk);
			byte_i       <= c;
			byte_valid_i <= 1'b1;
			if (mode_q[r] == MODE_RANDOM)
				field_ready_i <= draw_ready();
		end
		@(posedge clk);
		byte_valid_i <= 1'b0;
	endtask

	task automatic check_value(input string what, input logic [255:0] got,
			input logic [255:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic compare_record();
		int p;
		int lat;
		p = rec_count;
		rec_count++;
		if (p >= exp_tag_q.size()) begin
			errors++;
			$display("unexpected field record at %0t ns with tag %0h", $time, field_tag_o);
			return;
		end
		check_value("tag", 256'(field_tag_o), pack_ascii(exp_tag_q[p]));
		check_value("value", field_value_o, pack_ascii(exp_val_q[p]));
		check_value("length", 256'(field_len_o), 256'(exp_len_q[p]));
		check_value("msg_start", 256'(msg_start_o), 256'(exp_start_q[p]));
		check_value("msg_end", 256'(msg_end_o), 256'(exp_end_q[p]));
		check_value("index", 256'(field_index_o), 256'(exp_idx_q[p]));
		if (timing_on) begin
			if (soh_cycle_q.size() == 0) begin
				errors++;
				$display("field record at %0t ns came without a matching SOH", $time);
			end else begin
				lat = cycle_cnt - soh_cycle_q.pop_front();
				check_value("latency", 256'(lat), 256'(4));
			end
		end
	endtask

	// outputs settle after the rising edge, so look at them on the falling one.
	always @(negedge clk) begin
		if (!rst) begin
			if (timing_on && byte_valid_i && byte_i == fix_proto_pkg::soh_char)
				soh_cycle_q.push_back(cycle_cnt + 1); // taken on the coming edge.
			if (field_valid_o)
				compare_record();
		end
	end

	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		wait (table_loaded);
		repeat (200 * table_bytes) @(posedge clk);
		$display("timeout: the field records did not all arrive in time");
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		int r;
		int target;
		void'($urandom(32'hb5e6f1b5));
		rst           = 1'b1;
		byte_i        = '0;
		byte_valid_i  = 1'b0;
		field_ready_i = 1'b1;
		load_table();
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		target = 0;
		for (r = 0; r < msg_q.size(); r++) begin
			target += row_nexp_q[r];
			if (mode_q[r] == MODE_STALL) begin
				@(negedge clk);
				check_value("overflow before stall", 256'(overflow_o), 256'(0));
				@(posedge clk);
				field_ready_i <= 1'b0;
			end
			if (mode_q[r] == MODE_TIMED)
				timing_on = 1'b1;
			send_row(r);
			if (mode_q[r] == MODE_STALL) begin
				repeat (20) @(posedge clk);
				@(negedge clk);
				check_value("overflow after stall", 256'(overflow_o), 256'(1));
			end
			@(posedge clk);
			field_ready_i <= 1'b1;
			wait (rec_count >= target);
			repeat (10) @(posedge clk);
			timing_on = 1'b0;
		end
		check_value("record count", 256'(rec_count), 256'(exp_tag_q.size()));
		$display("%0d checks, %0d errors, %0d field records", checks, errors, rec_count);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- vlog.f
fix_proto_pkg.sv
fix_types_pkg.sv
fix_field_fifo.sv
fix_byte_tokenizer.sv
fix_field_assembler.sv
fix_field_reader.sv
fix_parser_top.sv
tb_fix_parser.sv
